// ==== build.f ====
hdc_pkg.sv
enc_ctrl_pkg.sv
encoder_fsm.sv
feature_counter.sv
feature_binder.sv
hv_bundler.sv
hv_credit_port.sv
hdc_encoder_top.sv
tb_clock_gen.sv
hdc_encoder_tb.sv

// ==== hdc_encoder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdc_encoder_tb;

    import hdc_pkg::*;
    import enc_ctrl_pkg::*;

    localparam int NUM_ROWS = 9;
    localparam int BP_HOLD  = 6; // cycles spent in done before a credit comes back
    localparam int TIMEOUT  = 100;

    typedef struct packed {
        feature_vec_t feats;
        logic         rand_feats;
        logic [3:0]   en_low;
        logic [3:0]   ret_delay;
        logic         withhold;
        logic         poke_start;
    } row_t;

    wire          clk;
    wire          nrst;
    logic         en;
    logic         start_encoding;
    feature_vec_t features;
    logic         credit_return;
    wire          out_valid;
    wire enc_result_t out_data;
    wire          bundling_features;
    wire          encoding_done;

    row_t    rows [NUM_ROWS];
    string   names [NUM_ROWS];
    credit_t credit_model;
    seq_t    exp_seq;

    tb_clock_gen tb_clock_gen_i (
        .clk  (clk),
        .nrst (nrst)
    );

    hdc_encoder_top hdc_encoder_top_i (
        .clk               (clk),
        .nrst              (nrst),
        .en                (en),
        .start_encoding    (start_encoding),
        .features          (features),
        .credit_return     (credit_return),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .bundling_features (bundling_features),
        .encoding_done     (encoding_done)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_hv(input string name, input hv_t exp, input hv_t act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_seq(input string name, input seq_t exp, input seq_t act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (exp != act) begin
            abort_run($sformatf("MISMATCH %s: expected %0d actual %0d", name, exp, act));
        end
    endtask

    // item memory lookup, XOR binding and a vote per bit as the encoding rules define them
    function automatic hv_t ref_encode(input feature_vec_t f);
        hv_t pos;
        hv_t lvl;
        hv_t res;
        int  votes [HV_DIM];
        for (int b = 0; b < HV_DIM; b++) votes[b] = 0;
        for (int i = 0; i < NUM_FEATURES; i++) begin
            for (int b = 0; b < HV_DIM; b++) begin
                pos[(b + POS_STEP * i) % HV_DIM] = ID_SEED[b];
                lvl[b] = LEVEL_SEED[b] ^ (b < LEVEL_STEP * int'(f[i]));
            end
            for (int b = 0; b < HV_DIM; b++) votes[b] += int'(pos[b] ^ lvl[b]);
        end
        for (int b = 0; b < HV_DIM; b++) res[b] = (votes[b] > NUM_FEATURES / 2);
        return res;
    endfunction

    // columns are features, random flag, en-low cycles, return delay, withhold, busy start
    task automatic fill_table();
        names[0] = "all_zero";
        rows[0]  = {32'h0000_0000, 1'b0, 4'd0, 4'd1, 1'b0, 1'b0};
        names[1] = "all_fifteen";
        rows[1]  = {32'hFFFF_FFFF, 1'b0, 4'd0, 4'd0, 1'b0, 1'b0};
        names[2] = "ramp_paused";
        rows[2]  = {32'h7654_3210, 1'b0, 4'd3, 4'd2, 1'b0, 1'b0};
        names[3] = "random_poked";
        rows[3]  = {32'h0000_0000, 1'b1, 4'd0, 4'd1, 1'b0, 1'b1};
        names[4] = "withhold_first";
        rows[4]  = {32'h3C5A_96E1, 1'b0, 4'd0, 4'd0, 1'b1, 1'b0};
        names[5] = "withhold_second";
        rows[5]  = {32'h0000_0000, 1'b1, 4'd0, 4'd0, 1'b1, 1'b0};
        names[6] = "backpressure";
        rows[6]  = {32'h8421_BDE7, 1'b0, 4'd0, 4'd0, 1'b0, 1'b0};
        names[7] = "random_paused";
        rows[7]  = {32'h0000_0000, 1'b1, 4'd5, 4'd3, 1'b0, 1'b0};
        names[8] = "alternate_poked";
        rows[8]  = {32'hF0F0_0F0F, 1'b0, 4'd1, 4'd2, 1'b0, 1'b1};
    endtask

    task automatic idle_start_ignored(input string name);
        @(posedge clk);
        en             <= 1'b0;
        start_encoding <= 1'b1;
        @(posedge clk);
        en             <= 1'b1;
        start_encoding <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag({name, " idle bundling"}, 1'b0, bundling_features);
            check_flag({name, " idle done"}, 1'b0, encoding_done);
            check_flag({name, " idle out_valid"}, 1'b0, out_valid);
        end
    endtask

    task automatic run_row(input int r);
        feature_vec_t feats;
        hv_t          exp_hv;
        logic         no_credit;
        logic         returned;
        logic         got;
        logic         pause;
        int           cycles;
        int           bund;
        int           done_cnt;
        int           low_left;
        feats     = rows[r].rand_feats ? feature_vec_t'($urandom()) : rows[r].feats;
        exp_hv    = ref_encode(feats);
        no_credit = (credit_model == 0);
        returned  = 1'b0;
        got       = 1'b0;
        cycles    = 0;
        bund      = 0;
        done_cnt  = 0;
        low_left  = rows[r].en_low;
        @(posedge clk);
        features       <= feats;
        en             <= 1'b1;
        start_encoding <= 1'b1;
        @(posedge clk);
        start_encoding <= 1'b0; // the encoder accepts on this edge
        while (!got) begin
            @(posedge clk);
            cycles++;
            pause = (low_left > 0) && (bund >= 3);
            if (pause) begin
                low_left--;
            end
            en             <= !pause;
            start_encoding <= rows[r].poke_start && (bund == 2);
            credit_return  <= no_credit && !returned && (done_cnt == BP_HOLD);
            if (no_credit && !returned && (done_cnt == BP_HOLD)) begin
                returned = 1'b1;
                credit_model++;
            end
            if (bund == 1) begin
                features <= ~feats; // the binder holds its own copy by now
            end
            @(negedge clk);
            if (bundling_features) bund++;
            if (encoding_done) done_cnt++;
            got = out_valid;
            if (got && no_credit && !returned) begin
                abort_run({names[r], ": result sent with no credit"});
            end
            if (cycles > TIMEOUT) begin
                abort_run({names[r], ": no result came out before the timeout"});
            end
        end
        check_cycles({names[r], " bundle cycles"}, 8 + rows[r].en_low, bund);
        if (no_credit) begin
            check_cycles({names[r], " done cycles"}, BP_HOLD + 2, done_cnt);
        end else begin
            check_cycles({names[r], " latency"}, 10 + rows[r].en_low, cycles);
        end
        check_hv(names[r], exp_hv, out_data.hv);
        check_seq(names[r], exp_seq, out_data.seq);
        exp_seq++;
        credit_model--;
        @(negedge clk);
        check_flag({names[r], " out_valid pulse"}, 1'b0, out_valid);
        check_flag({names[r], " done cleared"}, 1'b0, encoding_done);
        if (!rows[r].withhold) begin
            repeat (rows[r].ret_delay) @(posedge clk);
            @(posedge clk);
            credit_return <= 1'b1;
            @(posedge clk);
            credit_return <= 1'b0;
            if (credit_model < CREDIT_MAX) credit_model++;
        end
    endtask

    initial begin
        int t;
        en             = 1'b0;
        start_encoding = 1'b0;
        features       = '0;
        credit_return  = 1'b0;
        credit_model   = CREDIT_MAX;
        exp_seq        = '0;
        void'($urandom(3651));
        fill_table();
        t = 0;
        while (nrst !== 1'b1) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) abort_run("reset was never released");
        end
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset bundling", 1'b0, bundling_features);
        check_flag("reset done", 1'b0, encoding_done);
        idle_start_ignored("after_reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].poke_start) idle_start_ignored(names[r]);
            run_row(r);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // reset is held for ten rising edges and released away from them
    initial begin
        nrst = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        nrst <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdc_encoder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdc_encoder_top (
    input  wire                        clk,
    input  wire                        nrst,
    input  wire                        en,
    input  wire                        start_encoding,
    input  wire hdc_pkg::feature_vec_t features,
    input  wire                        credit_return,
    output wire                        out_valid,
    output wire hdc_pkg::enc_result_t  out_data,
    output wire                        bundling_features,
    output wire                        encoding_done
);

    import hdc_pkg::*;

    wire       load;
    wire       count_en;
    wire       last;
    wire       send_req;
    wire       sent;
    feat_idx_t ctr;
    hv_t       bound_hv;
    hv_t       majority_hv;

    encoder_fsm encoder_fsm_i (
        .clk               (clk),
        .nrst              (nrst),
        .en                (en),
        .start_encoding    (start_encoding),
        .last              (last),
        .sent              (sent),
        .load              (load),
        .count_en          (count_en),
        .send_req          (send_req),
        .bundling_features (bundling_features),
        .encoding_done     (encoding_done)
    );

    feature_counter feature_counter_i (
        .clk      (clk),
        .nrst     (nrst),
        .load     (load),
        .count_en (count_en),
        .ctr      (ctr),
        .last     (last)
    );

    feature_binder feature_binder_i (
        .clk      (clk),
        .nrst     (nrst),
        .load     (load),
        .features (features),
        .ctr      (ctr),
        .bound_hv (bound_hv)
    );

    hv_bundler hv_bundler_i (
        .clk         (clk),
        .nrst        (nrst),
        .load        (load),
        .count_en    (count_en),
        .bound_hv    (bound_hv),
        .majority_hv (majority_hv)
    );

    hv_credit_port hv_credit_port_i (
        .clk           (clk),
        .nrst          (nrst),
        .send_req      (send_req),
        .majority_hv   (majority_hv),
        .credit_return (credit_return),
        .sent          (sent),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

endmodule

`default_nettype wire

// ==== hv_credit_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module hv_credit_port (
    input  wire                  clk,
    input  wire                  nrst,
    input  wire                  send_req,
    input  wire hdc_pkg::hv_t    majority_hv,
    input  wire                  credit_return,
    output logic                 sent,
    output logic                 out_valid,
    output hdc_pkg::enc_result_t out_data
);

    import hdc_pkg::*;
    import enc_ctrl_pkg::*;

    credit_t credits;
    seq_t    seq_q;

    assign sent = send_req && (credits != '0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            credits   <= CREDIT_MAX;
            seq_q     <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= sent;
            if (sent) begin
                seq_q <= seq_q + 1'b1; // wraps at 256
            end
            // a return in the same cycle as a send cancels out
            if (sent && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (credit_return && !sent && (credits < CREDIT_MAX)) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sent) begin
            out_data.hv  <= majority_hv;
            out_data.seq <= seq_q;
        end
    end

    a_credit_cap: assert property (
        @(posedge clk) disable iff (!nrst)
        credits <= CREDIT_MAX
    );

    // every result pulse was paid for by a credit
    a_paid_send: assert property (
        @(posedge clk) disable iff (!nrst)
        out_valid |-> ($past(credits) != '0)
    );

endmodule

`default_nettype wire

// ==== hv_bundler.sv ====
`timescale 1ns/1ps
`default_nettype none

module hv_bundler (
    input  wire               clk,
    input  wire               nrst,
    input  wire               load,
    input  wire               count_en,
    input  wire hdc_pkg::hv_t bound_hv,
    output hdc_pkg::hv_t      majority_hv
);

    import hdc_pkg::*;

    logic [CNT_BITS-1:0] cnt [HV_DIM];

    // one vote counter per hypervector bit
    for (genvar b = 0; b < HV_DIM; b++) begin : g_bit

        always_ff @(posedge clk or negedge nrst) begin
            if (!nrst) begin
                cnt[b] <= '0;
            end else if (load) begin
                cnt[b] <= '0;
            end else if (count_en) begin
                cnt[b] <= cnt[b] + CNT_BITS'(bound_hv[b]);
            end
        end

        assign majority_hv[b] = (cnt[b] >= CNT_BITS'(MAJ_THRESH));

        // the FSM must clear the counters before more than NUM_FEATURES adds
        a_cnt_bound: assert property (
            @(posedge clk) disable iff (!nrst)
            cnt[b] <= CNT_BITS'(NUM_FEATURES)
        );

    end

endmodule

`default_nettype wire

// ==== feature_binder.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_binder (
    input  wire                   clk,
    input  wire                   nrst,
    input  wire                   load,
    input  wire hdc_pkg::feature_vec_t features,
    input  wire hdc_pkg::feat_idx_t    ctr,
    output hdc_pkg::hv_t          bound_hv
);

    import hdc_pkg::*;

    feature_vec_t feat_q;
    level_t       level;

    // position vector is the id seed rotated left by POS_STEP bits per index
    function automatic hv_t pos_hv(input feat_idx_t idx);
        int unsigned sh;
        sh = POS_STEP * idx;
        return (ID_SEED << sh) | (ID_SEED >> (HV_DIM - sh));
    endfunction

    // neighbouring levels differ in LEVEL_STEP low bits
    function automatic hv_t level_hv(input level_t lvl);
        int unsigned sh;
        hv_t         ones;
        sh   = LEVEL_STEP * lvl;
        ones = '1;
        return LEVEL_SEED ^ ~(ones << sh);
    endfunction

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            feat_q <= '0;
        end else if (load) begin
            feat_q <= features; // caller may change features while encoding runs
        end
    end

    assign level    = feat_q[ctr];
    assign bound_hv = pos_hv(ctr) ^ level_hv(level);

endmodule

`default_nettype wire

// ==== feature_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_counter (
    input  wire                clk,
    input  wire                nrst,
    input  wire                load,
    input  wire                count_en,
    output hdc_pkg::feat_idx_t ctr,
    output logic               last
);

    import hdc_pkg::*;

    // ctr is also the select value of the binder's feature mux
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ctr <= '0;
        end else if (load) begin
            ctr <= '0;
        end else if (count_en) begin
            ctr <= ctr + 1'b1; // wraps to 0 after the last position
        end
    end

    assign last = (ctr == feat_idx_t'(NUM_FEATURES - 1));

endmodule

`default_nettype wire

// ==== encoder_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module encoder_fsm (
    input  wire  clk,
    input  wire  nrst,
    input  wire  en,
    input  wire  start_encoding,
    input  wire  last,
    input  wire  sent,
    output logic load,
    output logic count_en,
    output logic send_req,
    output logic bundling_features,
    output logic encoding_done
);

    import enc_ctrl_pkg::*;

    enc_state_t state;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_encoding && en) begin
                        state <= S_BIND;
                    end
                end
                S_BIND: begin
                    state <= S_BUNDLE;
                end
                S_BUNDLE: begin
                    // a cycle with en low holds the counter, so wait for a counted last
                    if (count_en && last) begin
                        state <= S_ENC_DONE;
                    end
                end
                S_ENC_DONE: begin
                    if (sent) begin
                        state <= S_IDLE; // starts are ignored until the result is out
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign load              = (state == S_BIND);
    assign count_en          = (state == S_BUNDLE) && en;
    assign send_req          = (state == S_ENC_DONE);
    assign bundling_features = (state == S_BUNDLE);
    assign encoding_done     = (state == S_ENC_DONE);

    // the credit port must only answer a pending request
    a_sent_in_done: assert property (
        @(posedge clk) disable iff (!nrst)
        sent |-> (state == S_ENC_DONE)
    );

    a_load_one_cycle: assert property (
        @(posedge clk) disable iff (!nrst)
        load |=> !load
    );

endmodule

`default_nettype wire

// ==== enc_ctrl_pkg.sv ====
`default_nettype none

package enc_ctrl_pkg;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BIND,
        S_BUNDLE,
        S_ENC_DONE
    } enc_state_t;

    typedef logic [1:0] credit_t;

    // credits held by the encoder right after reset
    localparam credit_t CREDIT_MAX = 2'd2;

endpackage

`default_nettype wire

// ==== hdc_pkg.sv ====
`default_nettype none

package hdc_pkg;

    localparam int HV_DIM       = 64;
    localparam int NUM_FEATURES = 8;
    localparam int LEVEL_BITS   = 4;
    localparam int IDX_BITS     = $clog2(NUM_FEATURES);

    // per-bit bundling counters must reach NUM_FEATURES
    localparam int CNT_BITS   = $clog2(NUM_FEATURES + 1);
    localparam int MAJ_THRESH = NUM_FEATURES / 2 + 1; // a tie at four gives 0

    // item memory rule steps
    localparam int POS_STEP   = 8;  // rotate left per position
    localparam int LEVEL_STEP = 4;  // inverted low bits per level

    typedef logic [HV_DIM-1:0]     hv_t;
    typedef logic [LEVEL_BITS-1:0] level_t;
    typedef logic [IDX_BITS-1:0]   feat_idx_t;
    typedef logic [7:0]            seq_t;

    // index 0 is the first feature bundled
    typedef level_t [NUM_FEATURES-1:0] feature_vec_t;

    localparam hv_t ID_SEED    = 64'h9E37_79B9_7F4A_7C15;
    localparam hv_t LEVEL_SEED = 64'hC2B2_AE3D_27D4_EB4F;

    typedef struct packed {
        hv_t  hv;
        seq_t seq;
    } enc_result_t;

endpackage

`default_nettype wire
